// File: design/or1k_decode_defs.svh
// OR1K decode widths, instruction field positions and fixed register numbers
`ifndef OR1K_DECODE_DEFS_SVH
`define OR1K_DECODE_DEFS_SVH

// Datapath and field widths
`define OR1K_INSN_WIDTH      32
`define OR1K_OPERAND_WIDTH   32
`define OR1K_RF_ADDR_WIDTH   5
`define OR1K_IMM_WIDTH       16
`define OR1K_OPCODE_WIDTH    6
`define OR1K_ALU_OPC_WIDTH   4

// Return address register written by l.jal and l.jalr
`define OR1K_LINK_REG        9

// Instruction word fields
`define OR1K_OPCODE_MSB      31
`define OR1K_OPCODE_LSB      26
`define OR1K_RD_MSB          25
`define OR1K_RD_LSB          21
`define OR1K_RA_MSB          20
`define OR1K_RA_LSB          16
`define OR1K_RB_MSB          15
`define OR1K_RB_LSB          11
`define OR1K_ALU_OPC_MSB     3
`define OR1K_ALU_OPC_LSB     0
`define OR1K_SHIFT_KIND_MSB  7
`define OR1K_SHIFT_KIND_LSB  6
`define OR1K_COMP_MSB        25
`define OR1K_COMP_LSB        21
`define OR1K_SYS_MSB         25
`define OR1K_SYS_LSB         21

`endif

// File: design/or1k_decode_pkg.sv
// Opcode, ALU, shift, system and load/store length encodings of the OR1K decoder
`include "or1k_decode_defs.svh"

package or1k_decode_pkg;

   // Major opcodes of the supported instruction set
   typedef enum logic [`OR1K_OPCODE_WIDTH-1:0] {
      OPC_J     = 6'h00,
      OPC_JAL   = 6'h01,
      OPC_BNF   = 6'h03,
      OPC_BF    = 6'h04,
      OPC_NOP   = 6'h05,
      OPC_MOVHI = 6'h06,
      OPC_SYS   = 6'h08,
      OPC_RFE   = 6'h09,
      OPC_JR    = 6'h11,
      OPC_JALR  = 6'h12,
      OPC_LWZ   = 6'h21,
      OPC_LWS   = 6'h22,
      OPC_LBZ   = 6'h23,
      OPC_LBS   = 6'h24,
      OPC_LHZ   = 6'h25,
      OPC_LHS   = 6'h26,
      OPC_ADDI  = 6'h27,
      OPC_ANDI  = 6'h29,
      OPC_ORI   = 6'h2A,
      OPC_XORI  = 6'h2B,
      OPC_MULI  = 6'h2C,
      OPC_MFSPR = 6'h2D,
      OPC_SHRTI = 6'h2E,
      OPC_SFIMM = 6'h2F,
      OPC_MTSPR = 6'h30,
      OPC_SW    = 6'h35,
      OPC_SB    = 6'h36,
      OPC_SH    = 6'h37,
      OPC_ALU   = 6'h38,
      OPC_SF    = 6'h39
   } opcode_e;

   // Low nibble of the ALU-group instructions
   typedef enum logic [`OR1K_ALU_OPC_WIDTH-1:0] {
      ALU_ADD  = 4'd0,
      ALU_ADDC = 4'd1,
      ALU_SUB  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_MUL  = 4'd6,
      ALU_SHRT = 4'd8,
      ALU_MULU = 4'd11
   } alu_opc_e;

   typedef enum logic [`OR1K_SHIFT_KIND_MSB-`OR1K_SHIFT_KIND_LSB:0] {
      SHIFT_SLL = 2'd0,
      SHIFT_SRL = 2'd1,
      SHIFT_SRA = 2'd2,
      SHIFT_ROR = 2'd3
   } shift_kind_e;

   typedef enum logic [`OR1K_SYS_MSB-`OR1K_SYS_LSB:0] {
      SYS_SYSCALL = 5'h00,
      SYS_TRAP    = 5'h08
   } sys_opc_e;

   typedef enum logic [1:0] {
      LSU_BYTE = 2'd0,
      LSU_HALF = 2'd1,
      LSU_WORD = 2'd2
   } lsu_len_e;

endpackage

// File: design/decode_class.sv
// Operation class decode: unit flags, writeback, destination register and LSU length
`timescale 1ns/1ps
`include "or1k_decode_defs.svh"

module decode_class import or1k_decode_pkg::*; (
   input  logic [`OR1K_INSN_WIDTH-1:0]    insn_i,
   output logic                           op_alu_o,
   output logic                           op_load_o,
   output logic                           op_store_o,
   output logic                           op_jbr_o,
   output logic                           op_jr_o,
   output logic                           op_jal_o,
   output logic                           op_bf_o,
   output logic                           op_bnf_o,
   output logic                           op_branch_o,
   output logic                           op_setflag_o,
   output logic                           op_add_o,
   output logic                           op_mul_o,
   output logic                           op_shift_o,
   output logic                           op_movhi_o,
   output logic                           op_mfspr_o,
   output logic                           op_mtspr_o,
   output logic                           op_rfe_o,
   output logic                           rf_wb_o,
   output logic                           lsu_zext_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0] rfd_adr_o,
   output lsu_len_e                       lsu_length_o
);

   opcode_e  opc;
   alu_opc_e alu_opc;
   logic     alu_grp;

   assign opc     = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);
   assign alu_opc = alu_opc_e'(insn_i[`OR1K_ALU_OPC_MSB:`OR1K_ALU_OPC_LSB]);
   assign alu_grp = (opc == OPC_ALU);

   // Memory access
   assign op_load_o  = opc inside {OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS};
   assign op_store_o = opc inside {OPC_SW, OPC_SB, OPC_SH};
   // Odd load opcodes are the zero-extending ones
   assign lsu_zext_o = opc[0];

   // Jumps and branches
   assign op_jbr_o    = opc inside {OPC_J, OPC_JAL, OPC_BNF, OPC_BF};
   assign op_jr_o     = opc inside {OPC_JR, OPC_JALR};
   assign op_jal_o    = opc inside {OPC_JAL, OPC_JALR};
   assign op_bf_o     = (opc == OPC_BF);
   assign op_bnf_o    = (opc == OPC_BNF);
   assign op_branch_o = op_jbr_o | op_jr_o;

   // Execution units
   assign op_alu_o     = opc inside {OPC_ALU, OPC_ANDI, OPC_ORI, OPC_XORI};
   assign op_add_o     = (alu_grp && alu_opc inside {ALU_ADD, ALU_SUB}) || opc == OPC_ADDI;
   assign op_mul_o     = (alu_grp && alu_opc inside {ALU_MUL, ALU_MULU}) || opc == OPC_MULI;
   assign op_shift_o   = (alu_grp && alu_opc == ALU_SHRT) || opc == OPC_SHRTI;
   assign op_setflag_o = opc inside {OPC_SF, OPC_SFIMM};
   assign op_movhi_o   = (opc == OPC_MOVHI);
   assign op_mfspr_o   = (opc == OPC_MFSPR);
   assign op_mtspr_o   = (opc == OPC_MTSPR);
   assign op_rfe_o     = (opc == OPC_RFE);

   // 10xxxx writes back except l.sfxxi, 11xxxx except compares, mtspr and stores
   assign rf_wb_o = op_jal_o || op_movhi_o ||
                    (opc[5:4] == 2'b10 && opc != OPC_SFIMM) ||
                    (opc[5:4] == 2'b11 && !(opc == OPC_SF || op_mtspr_o || op_store_o));

   assign rfd_adr_o = op_jal_o ? `OR1K_RF_ADDR_WIDTH'(`OR1K_LINK_REG) :
                                 insn_i[`OR1K_RD_MSB:`OR1K_RD_LSB];

   always_comb begin
      case (opc)
         OPC_SB, OPC_LBZ, OPC_LBS: lsu_length_o = LSU_BYTE;
         OPC_SH, OPC_LHZ, OPC_LHS: lsu_length_o = LSU_HALF;
         default:                  lsu_length_o = LSU_WORD;
      endcase
   end

   // One instruction goes to one unit at most
   a_one_class: assert final ($onehot0({op_load_o, op_store_o, op_setflag_o, op_add_o,
                                        op_mul_o, op_shift_o, op_movhi_o, op_mfspr_o,
                                        op_mtspr_o, op_rfe_o, op_branch_o}))
      else $error("decode_class: several operation classes active");

endmodule

// File: design/decode_imm.sv
// Immediate decode: reassembles split fields and picks sign, zero or high extension
`timescale 1ns/1ps
`include "or1k_decode_defs.svh"

module decode_imm import or1k_decode_pkg::*; (
   input  logic [`OR1K_INSN_WIDTH-1:0]    insn_i,
   input  logic                           op_store_i,
   input  logic                           op_mtspr_i,
   input  logic                           op_movhi_i,
   output logic [`OR1K_IMM_WIDTH-1:0]     imm16_o,
   output logic [`OR1K_OPERAND_WIDTH-1:0] immediate_o,
   output logic                           immediate_sel_o
);

   localparam int unsigned EXT_W = `OR1K_OPERAND_WIDTH - `OR1K_IMM_WIDTH;

   opcode_e                        opc;
   logic                           sext_sel;
   logic                           zext_sel;
   logic [`OR1K_OPERAND_WIDTH-1:0] imm_sext;
   logic [`OR1K_OPERAND_WIDTH-1:0] imm_zext;
   logic [`OR1K_OPERAND_WIDTH-1:0] imm_high;

   assign opc = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);

   // Stores and mtspr carry rB in bits 15:11, so the top of the immediate sits in rd
   assign imm16_o = (op_store_i || op_mtspr_i) ?
                    {insn_i[`OR1K_RD_MSB:`OR1K_RD_LSB], insn_i[`OR1K_RB_LSB-1:0]} :
                    insn_i[`OR1K_IMM_WIDTH-1:0];

   // Logic immediates and SPR numbers are unsigned
   assign zext_sel = (opc inside {OPC_ANDI, OPC_ORI}) || op_mtspr_i;
   assign sext_sel = (opc[5:4] == 2'b10 && !(opc inside {OPC_ANDI, OPC_ORI})) || op_store_i;

   assign imm_sext = {{EXT_W{imm16_o[`OR1K_IMM_WIDTH-1]}}, imm16_o};
   assign imm_zext = {{EXT_W{1'b0}}, imm16_o};
   assign imm_high = {imm16_o, {EXT_W{1'b0}}};

   assign immediate_o     = sext_sel ? imm_sext : (zext_sel ? imm_zext : imm_high);
   assign immediate_sel_o = sext_sel | zext_sel | op_movhi_i;

   // Class flags from decode_class never ask for two extensions at once
   a_one_imm_sel: assert final ($onehot0({sext_sel, zext_sel, op_movhi_i}))
      else $error("decode_imm: more than one immediate select active");

endmodule

// File: design/decode_alu_ctrl.sv
// ALU control decode: ALU opcode, secondary opcode and adder subtract
`timescale 1ns/1ps
`include "or1k_decode_defs.svh"

module decode_alu_ctrl import or1k_decode_pkg::*; (
   input  logic [`OR1K_INSN_WIDTH-1:0]        insn_i,
   input  logic                               op_setflag_i,
   output alu_opc_e                           opc_alu_o,
   output logic [`OR1K_COMP_MSB-`OR1K_COMP_LSB:0] opc_alu_secondary_o,
   output logic                               adder_do_sub_o
);

   opcode_e  opc;
   alu_opc_e alu_opc;

   assign opc     = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);
   assign alu_opc = alu_opc_e'(insn_i[`OR1K_ALU_OPC_MSB:`OR1K_ALU_OPC_LSB]);

   // Immediate logic ops have no ALU nibble of their own
   always_comb begin
      case (opc)
         OPC_ANDI: opc_alu_o = ALU_AND;
         OPC_ORI:  opc_alu_o = ALU_OR;
         OPC_XORI: opc_alu_o = ALU_XOR;
         default:  opc_alu_o = alu_opc;
      endcase
   end

   // Compare condition for l.sf*, shift kind padded to 5 bits for everything else
   assign opc_alu_secondary_o = op_setflag_i ? insn_i[`OR1K_COMP_MSB:`OR1K_COMP_LSB] :
                                {3'b000, insn_i[`OR1K_SHIFT_KIND_MSB:`OR1K_SHIFT_KIND_LSB]};

   // Compares use a - b too
   assign adder_do_sub_o = (opc == OPC_ALU && alu_opc == ALU_SUB) || op_setflag_i;

endmodule

// File: design/decode_illegal.sv
// Illegal instruction check with syscall and trap decode
`timescale 1ns/1ps
`include "or1k_decode_defs.svh"

module decode_illegal import or1k_decode_pkg::*; (
   input  logic [`OR1K_INSN_WIDTH-1:0] insn_i,
   output logic                        except_illegal_o,
   output logic                        except_syscall_o,
   output logic                        except_trap_o
);

   opcode_e     opc;
   alu_opc_e    alu_opc;
   shift_kind_e shift_kind;
   sys_opc_e    sys_opc;
   logic        shift_ok;

   assign opc        = opcode_e'(insn_i[`OR1K_OPCODE_MSB:`OR1K_OPCODE_LSB]);
   assign alu_opc    = alu_opc_e'(insn_i[`OR1K_ALU_OPC_MSB:`OR1K_ALU_OPC_LSB]);
   assign shift_kind = shift_kind_e'(insn_i[`OR1K_SHIFT_KIND_MSB:`OR1K_SHIFT_KIND_LSB]);
   assign sys_opc    = sys_opc_e'(insn_i[`OR1K_SYS_MSB:`OR1K_SYS_LSB]);

   // No rotator in this core
   assign shift_ok = (shift_kind != SHIFT_ROR);

   always_comb begin
      case (opc)
         OPC_J, OPC_JAL, OPC_BNF, OPC_BF, OPC_NOP, OPC_MOVHI, OPC_RFE,
         OPC_JR, OPC_JALR, OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ,
         OPC_LHS, OPC_ADDI, OPC_ANDI, OPC_ORI, OPC_XORI, OPC_MULI,
         OPC_MFSPR, OPC_SFIMM, OPC_MTSPR, OPC_SW, OPC_SB, OPC_SH, OPC_SF:
            except_illegal_o = 1'b0;
         OPC_SYS:
            except_illegal_o = !(sys_opc inside {SYS_SYSCALL, SYS_TRAP});
         OPC_SHRTI:
            except_illegal_o = !shift_ok;
         OPC_ALU: begin
            case (alu_opc)
               ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_MUL, ALU_MULU:
                  except_illegal_o = 1'b0;
               ALU_SHRT:
                  except_illegal_o = !shift_ok;
               // addc, div, ffl1, cmov, ext and the rest
               default:
                  except_illegal_o = 1'b1;
            endcase
         end
         default:
            except_illegal_o = 1'b1;
      endcase
   end

   assign except_syscall_o = (opc == OPC_SYS) && (sys_opc == SYS_SYSCALL);
   assign except_trap_o    = (opc == OPC_SYS) && (sys_opc == SYS_TRAP);

   // A system exception is never also reported as illegal or as the other kind
   a_sys_excl: assert final (!(except_syscall_o && except_trap_o) &&
                             !((except_syscall_o || except_trap_o) && except_illegal_o))
      else $error("decode_illegal: conflicting exception decodes");

endmodule

// File: design/decode_stage.sv
// OR1K decode stage: combinational decoders into the decode-to-execute register
`timescale 1ns/1ps
`include "or1k_decode_defs.svh"

module decode_stage import or1k_decode_pkg::*; (
   input  logic                               clk,
   input  logic                               rst_n_i,
   input  logic [`OR1K_INSN_WIDTH-1:0]        insn_i,
   input  logic                               insn_valid_i,
   output logic                               valid_o,
   output alu_opc_e                           opc_alu_o,
   output logic [`OR1K_COMP_MSB-`OR1K_COMP_LSB:0] opc_alu_secondary_o,
   output logic [`OR1K_IMM_WIDTH-1:0]         imm16_o,
   output logic [`OR1K_OPERAND_WIDTH-1:0]     immediate_o,
   output logic                               immediate_sel_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0]     rfd_adr_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0]     rfa_adr_o,
   output logic [`OR1K_RF_ADDR_WIDTH-1:0]     rfb_adr_o,
   output logic                               rf_wb_o,
   output logic                               op_alu_o,
   output logic                               op_load_o,
   output logic                               op_store_o,
   output logic                               op_jbr_o,
   output logic                               op_jr_o,
   output logic                               op_jal_o,
   output logic                               op_bf_o,
   output logic                               op_bnf_o,
   output logic                               op_branch_o,
   output logic                               op_setflag_o,
   output logic                               op_add_o,
   output logic                               op_mul_o,
   output logic                               op_shift_o,
   output logic                               op_movhi_o,
   output logic                               op_mfspr_o,
   output logic                               op_mtspr_o,
   output logic                               op_rfe_o,
   output lsu_len_e                           lsu_length_o,
   output logic                               lsu_zext_o,
   output logic                               adder_do_sub_o,
   output logic                               except_illegal_o,
   output logic                               except_syscall_o,
   output logic                               except_trap_o
);

   // Single-bit decodes, bit 23 down to 0 in the order of the output concatenation
   logic [23:0]                        flags_d;
   logic [23:0]                        flags_q;
   alu_opc_e                           opc_alu_d;
   logic [`OR1K_COMP_MSB-`OR1K_COMP_LSB:0] secondary_d;
   logic [`OR1K_IMM_WIDTH-1:0]         imm16_d;
   logic [`OR1K_OPERAND_WIDTH-1:0]     immediate_d;
   logic [`OR1K_RF_ADDR_WIDTH-1:0]     rfd_adr_d;
   lsu_len_e                           lsu_length_d;

   decode_class u_class (
      .insn_i       (insn_i),
      .op_alu_o     (flags_d[23]),
      .op_load_o    (flags_d[22]),
      .op_store_o   (flags_d[21]),
      .op_jbr_o     (flags_d[20]),
      .op_jr_o      (flags_d[19]),
      .op_jal_o     (flags_d[18]),
      .op_bf_o      (flags_d[17]),
      .op_bnf_o     (flags_d[16]),
      .op_branch_o  (flags_d[15]),
      .op_setflag_o (flags_d[14]),
      .op_add_o     (flags_d[13]),
      .op_mul_o     (flags_d[12]),
      .op_shift_o   (flags_d[11]),
      .op_movhi_o   (flags_d[10]),
      .op_mfspr_o   (flags_d[9]),
      .op_mtspr_o   (flags_d[8]),
      .op_rfe_o     (flags_d[7]),
      .rf_wb_o      (flags_d[6]),
      .lsu_zext_o   (flags_d[5]),
      .rfd_adr_o    (rfd_adr_d),
      .lsu_length_o (lsu_length_d)
   );

   // Store, mtspr and movhi flags steer the immediate
   decode_imm u_imm (
      .insn_i          (insn_i),
      .op_store_i      (flags_d[21]),
      .op_mtspr_i      (flags_d[8]),
      .op_movhi_i      (flags_d[10]),
      .imm16_o         (imm16_d),
      .immediate_o     (immediate_d),
      .immediate_sel_o (flags_d[4])
   );

   decode_alu_ctrl u_alu_ctrl (
      .insn_i              (insn_i),
      .op_setflag_i        (flags_d[14]),
      .opc_alu_o           (opc_alu_d),
      .opc_alu_secondary_o (secondary_d),
      .adder_do_sub_o      (flags_d[3])
   );

   decode_illegal u_illegal (
      .insn_i           (insn_i),
      .except_illegal_o (flags_d[2]),
      .except_syscall_o (flags_d[1]),
      .except_trap_o    (flags_d[0])
   );

   // Valid bit and decode flags clear on reset
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_o <= 1'b0;
         flags_q <= '0;
      end else begin
         valid_o <= insn_valid_i;
         if (insn_valid_i) begin
            flags_q <= flags_d;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (insn_valid_i) begin
         opc_alu_o           <= opc_alu_d;
         opc_alu_secondary_o <= secondary_d;
         imm16_o             <= imm16_d;
         immediate_o         <= immediate_d;
         rfd_adr_o           <= rfd_adr_d;
         rfa_adr_o           <= insn_i[`OR1K_RA_MSB:`OR1K_RA_LSB];
         rfb_adr_o           <= insn_i[`OR1K_RB_MSB:`OR1K_RB_LSB];
         lsu_length_o        <= lsu_length_d;
      end
   end

   assign {op_alu_o, op_load_o, op_store_o, op_jbr_o, op_jr_o, op_jal_o,
           op_bf_o, op_bnf_o, op_branch_o, op_setflag_o, op_add_o, op_mul_o,
           op_shift_o, op_movhi_o, op_mfspr_o, op_mtspr_o, op_rfe_o, rf_wb_o,
           lsu_zext_o, immediate_sel_o, adder_do_sub_o, except_illegal_o,
           except_syscall_o, except_trap_o} = flags_q;

   // Stage is still empty on the first edge after reset release
   a_valid_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !valid_o)
      else $error("decode_stage: valid_o high right after reset");

endmodule

// File: sim/tb_decode_model.svh
// Reference decode of OR1K instruction words for the decode stage testbench
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// Positions in the packed flag vector, gathered MSB first like the DUT outputs
localparam int FL_LOAD    = 22;
localparam int FL_STORE   = 21;
localparam int FL_ZEXT    = 5;
localparam int FL_IMM_SEL = 4;

function automatic logic is_legal(input logic [31:0] w);
   logic [5:0] op;
   logic [3:0] nib;
   logic       ror;
   op  = w[31:26];
   nib = w[3:0];
   ror = (w[7:6] == 2'b11);
   case (op)
      6'h00, 6'h01, 6'h03, 6'h04, 6'h05, 6'h06, 6'h09, 6'h11, 6'h12,
      6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h29, 6'h2A,
      6'h2B, 6'h2C, 6'h2D, 6'h2F, 6'h30, 6'h35, 6'h36, 6'h37, 6'h39:
         return 1'b1;
      6'h08:
         return (w[25:21] == 5'h00) || (w[25:21] == 5'h08);
      6'h2E:
         return !ror;
      6'h38:
         return (nib inside {4'd0, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd11}) ||
                (nib == 4'd8 && !ror);
      default:
         return 1'b0;
   endcase
endfunction

function automatic logic [23:0] flags_for(input logic [31:0] w);
   logic [5:0] op;
   logic [3:0] nib;
   logic       alu_grp, load, store, jbr, jr, jal, setflag, movhi, mtspr;
   logic       add, mul, shift, wb, sext, zext_imm, sub, zext_ld;
   op       = w[31:26];
   nib      = w[3:0];
   alu_grp  = (op == 6'h38);
   load     = (op >= 6'h21) && (op <= 6'h26);
   store    = (op >= 6'h35) && (op <= 6'h37);
   jbr      = (op == 6'h00) || (op == 6'h01) || (op == 6'h03) || (op == 6'h04);
   jr       = (op == 6'h11) || (op == 6'h12);
   jal      = (op == 6'h01) || (op == 6'h12);
   setflag  = (op == 6'h39) || (op == 6'h2F);
   movhi    = (op == 6'h06);
   mtspr    = (op == 6'h30);
   add      = (alu_grp && (nib == 4'd0 || nib == 4'd2)) || (op == 6'h27);
   mul      = (alu_grp && (nib == 4'd6 || nib == 4'd11)) || (op == 6'h2C);
   shift    = (alu_grp && nib == 4'd8) || (op == 6'h2E);
   // 0x20 to 0x2E write rD, above 0x30 everything but compares, mtspr and stores
   wb       = jal || movhi || (op >= 6'h20 && op <= 6'h2E) ||
              (op >= 6'h30 && !(op == 6'h39 || mtspr || store));
   sext     = (op >= 6'h20 && op <= 6'h2F && op != 6'h29 && op != 6'h2A) || store;
   zext_imm = (op == 6'h29) || (op == 6'h2A) || mtspr;
   sub      = (alu_grp && nib == 4'd2) || setflag;
   // l.lwz, l.lbz and l.lhz
   zext_ld  = (op == 6'h21) || (op == 6'h23) || (op == 6'h25);
   return {alu_grp || op == 6'h29 || op == 6'h2A || op == 6'h2B, load, store, jbr,
           jr, jal, op == 6'h04, op == 6'h03, jbr || jr, setflag, add, mul, shift,
           movhi, op == 6'h2D, mtspr, op == 6'h09, wb, zext_ld,
           sext || zext_imm || movhi, sub, !is_legal(w),
           op == 6'h08 && w[25:21] == 5'h00, op == 6'h08 && w[25:21] == 5'h08};
endfunction

function automatic logic [15:0] imm16_for(input logic [31:0] w);
   logic split;
   split = (w[31:26] >= 6'h35 && w[31:26] <= 6'h37) || (w[31:26] == 6'h30);
   return split ? {w[25:21], w[10:0]} : w[15:0];
endfunction

// Only meaningful where the immediate select is expected high
function automatic logic [31:0] immediate_for(input logic [31:0] w);
   logic [15:0] i;
   logic [5:0]  op;
   i  = imm16_for(w);
   op = w[31:26];
   if (op == 6'h29 || op == 6'h2A || op == 6'h30)
      return {16'h0000, i};
   if (op == 6'h06)
      return {i, 16'h0000};
   return {{16{i[15]}}, i};
endfunction

function automatic logic [3:0] alu_opc_for(input logic [31:0] w);
   case (w[31:26])
      6'h29:   return 4'd3;
      6'h2A:   return 4'd4;
      6'h2B:   return 4'd5;
      default: return w[3:0];
   endcase
endfunction

function automatic logic [4:0] secondary_for(input logic [31:0] w);
   if (w[31:26] == 6'h39 || w[31:26] == 6'h2F)
      return w[25:21];
   return {3'b000, w[7:6]};
endfunction

function automatic logic [4:0] rfd_for(input logic [31:0] w);
   return (w[31:26] == 6'h01 || w[31:26] == 6'h12) ? 5'd9 : w[25:21];
endfunction

function automatic logic [1:0] lsu_len_for(input logic [31:0] w);
   case (w[31:26])
      6'h23, 6'h24, 6'h36: return 2'd0;
      6'h25, 6'h26, 6'h37: return 2'd1;
      default:             return 2'd2;
   endcase
endfunction

`endif

// File: sim/tb_decode_stage.sv
// Directed and random testbench for the OR1K decode stage
`timescale 1ns/1ps

module tb_decode_stage import or1k_decode_pkg::*; ();

   localparam int CLK_PERIOD  = 4;
   // Reset, class, immediate, ALU control, illegal and stream tests in cycles
   localparam int TEST_CYCLES = 11 + 2 * (30 + 16 + 1) + 2 * 6 + 2 * 6 + 2 * 14 + 201;
   localparam int MARGIN      = 100;

   logic        clk;
   logic        rst_n_i;
   logic [31:0] insn_i;
   logic        insn_valid_i;
   logic        valid_o;
   alu_opc_e    opc_alu_o;
   logic [4:0]  opc_alu_secondary_o;
   logic [15:0] imm16_o;
   logic [31:0] immediate_o;
   logic        immediate_sel_o;
   logic [4:0]  rfd_adr_o, rfa_adr_o, rfb_adr_o;
   logic        rf_wb_o, op_alu_o, op_load_o, op_store_o, op_jbr_o, op_jr_o;
   logic        op_jal_o, op_bf_o, op_bnf_o, op_branch_o, op_setflag_o, op_add_o;
   logic        op_mul_o, op_shift_o, op_movhi_o, op_mfspr_o, op_mtspr_o, op_rfe_o;
   lsu_len_e    lsu_length_o;
   logic        lsu_zext_o, adder_do_sub_o;
   logic        except_illegal_o, except_syscall_o, except_trap_o;
   logic [23:0] dut_flags;
   integer      seed;
   int          errors;
   int          n_checked;

   `include "tb_decode_model.svh"

   decode_stage u_dut (.*);

   assign dut_flags = {op_alu_o, op_load_o, op_store_o, op_jbr_o, op_jr_o, op_jal_o,
                       op_bf_o, op_bnf_o, op_branch_o, op_setflag_o, op_add_o, op_mul_o,
                       op_shift_o, op_movhi_o, op_mfspr_o, op_mtspr_o, op_rfe_o, rf_wb_o,
                       lsu_zext_o, immediate_sel_o, adder_do_sub_o, except_illegal_o,
                       except_syscall_o, except_trap_o};

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
      $display("Timeout: tests did not finish within %0d cycles", TEST_CYCLES + MARGIN);
      $display("Testbench failed");
      $finish;
   end

   task automatic report_mismatch(input string what, input logic [31:0] w,
                                  input logic [31:0] got, input logic [31:0] exp);
      errors++;
      $display("CHECK FAILED at %0t ns: %s for insn %08h, got %0h, expected %0h",
               $time, what, w, got, exp);
   endtask

   task automatic check_outputs(input logic [31:0] w);
      logic [23:0] exp_flags;
      logic [23:0] mask;
      exp_flags = flags_for(w);
      mask      = '1;
      // Zero-extend flag only matters on loads
      mask[FL_ZEXT] = exp_flags[FL_LOAD];
      n_checked++;
      if ((dut_flags & mask) !== (exp_flags & mask))
         report_mismatch("class flags", w, dut_flags, exp_flags);
      if (rfd_adr_o !== rfd_for(w))
         report_mismatch("rD address", w, rfd_adr_o, rfd_for(w));
      if (rfa_adr_o !== w[20:16])
         report_mismatch("rA address", w, rfa_adr_o, w[20:16]);
      if (rfb_adr_o !== w[15:11])
         report_mismatch("rB address", w, rfb_adr_o, w[15:11]);
      if (imm16_o !== imm16_for(w))
         report_mismatch("imm16", w, imm16_o, imm16_for(w));
      if (exp_flags[FL_IMM_SEL] && immediate_o !== immediate_for(w))
         report_mismatch("immediate", w, immediate_o, immediate_for(w));
      if (opc_alu_o !== alu_opc_for(w))
         report_mismatch("ALU opcode", w, opc_alu_o, alu_opc_for(w));
      if (opc_alu_secondary_o !== secondary_for(w))
         report_mismatch("secondary opcode", w, opc_alu_secondary_o, secondary_for(w));
      if ((exp_flags[FL_LOAD] || exp_flags[FL_STORE]) && lsu_length_o !== lsu_len_for(w))
         report_mismatch("LSU length", w, lsu_length_o, lsu_len_for(w));
   endtask

   // One valid word, result checked one rising edge later
   task automatic decode_one(input logic [31:0] w);
      @(negedge clk);
      insn_i       = w;
      insn_valid_i = 1'b1;
      @(negedge clk);
      insn_valid_i = 1'b0;
      if (valid_o !== 1'b1)
         report_mismatch("valid_o", w, valid_o, 1);
      check_outputs(w);
   endtask

   task automatic expect_immediate(input logic [31:0] w, input logic [31:0] imm,
                                   input logic sel);
      decode_one(w);
      if (immediate_sel_o !== sel)
         report_mismatch("immediate select", w, immediate_sel_o, sel);
      if (sel && immediate_o !== imm)
         report_mismatch("immediate value", w, immediate_o, imm);
   endtask

   task automatic expect_alu(input logic [31:0] w, input logic [3:0] opc,
                             input logic [4:0] sec, input logic sub);
      decode_one(w);
      if (opc_alu_o !== opc)
         report_mismatch("ALU opcode", w, opc_alu_o, opc);
      if (opc_alu_secondary_o !== sec)
         report_mismatch("secondary opcode", w, opc_alu_secondary_o, sec);
      if (adder_do_sub_o !== sub)
         report_mismatch("adder subtract", w, adder_do_sub_o, sub);
   endtask

   task automatic expect_except(input logic [31:0] w, input logic ill,
                                input logic sc, input logic tr);
      decode_one(w);
      if ({except_illegal_o, except_syscall_o, except_trap_o} !== {ill, sc, tr})
         report_mismatch("exceptions", w,
                         {except_illegal_o, except_syscall_o, except_trap_o}, {ill, sc, tr});
   endtask

   task automatic test_reset;
      rst_n_i      = 1'b0;
      // A valid word during reset must not get through
      insn_i       = {6'h38, 5'd1, 5'd2, 5'd3, 11'h000};
      insn_valid_i = 1'b1;
      repeat (10) begin
         @(negedge clk);
         if (valid_o !== 1'b0 || dut_flags !== '0)
            report_mismatch("outputs in reset", insn_i, {valid_o, dut_flags}, 0);
      end
      insn_valid_i = 1'b0;
      rst_n_i      = 1'b1;
      @(negedge clk);
      if (valid_o !== 1'b0 || dut_flags !== '0)
         report_mismatch("outputs after reset", insn_i, {valid_o, dut_flags}, 0);
   endtask

   task automatic test_classes;
      logic [31:0] w;
      logic [6:0]  op;
      logic [4:0]  nib;
      for (op = 0; op < 64; op++) begin
         w = {op[5:0], 5'd8, 5'd12, 16'h8C40};
         if (is_legal(w)) begin
            decode_one(w);
         end
      end
      // All sixteen ALU-group nibbles with a logical right shift kind
      for (nib = 0; nib < 16; nib++)
         decode_one({6'h38, 5'd4, 5'd5, 5'd6, 3'b000, 2'b01, 2'b00, nib[3:0]});
      decode_one({6'h12, 5'd3, 5'd0, 5'd7, 11'h000});
      if (rfd_adr_o !== 5'd9)
         report_mismatch("link register", insn_i, rfd_adr_o, 9);
   endtask

   task automatic test_immediates;
      expect_immediate({6'h27, 5'd1, 5'd2, 16'hFFF0}, 32'hFFFF_FFF0, 1'b1);
      expect_immediate({6'h2A, 5'd1, 5'd2, 16'h8001}, 32'h0000_8001, 1'b1);
      expect_immediate({6'h06, 5'd3, 5'd0, 16'hBEEF}, 32'hBEEF_0000, 1'b1);
      expect_immediate({6'h35, 5'b10101, 5'd2, 5'd3, 11'h7FF}, 32'hFFFF_AFFF, 1'b1);
      expect_immediate({6'h30, 5'b10001, 5'd4, 5'd5, 11'h123}, 32'h0000_8923, 1'b1);
      expect_immediate({6'h38, 5'd1, 5'd2, 5'd3, 11'h000}, 32'h0, 1'b0);
   endtask

   task automatic test_alu_ctrl;
      expect_alu({6'h29, 5'd1, 5'd2, 16'h00CF}, 4'd3, 5'd3, 1'b0);
      expect_alu({6'h2A, 5'd1, 5'd2, 16'h000F}, 4'd4, 5'd0, 1'b0);
      expect_alu({6'h2B, 5'd1, 5'd2, 16'h004E}, 4'd5, 5'd1, 1'b0);
      expect_alu({6'h39, 5'h0B, 5'd1, 5'd2, 11'h000}, 4'd0, 5'h0B, 1'b1);
      expect_alu({6'h38, 5'd1, 5'd2, 5'd3, 11'h002}, 4'd2, 5'd0, 1'b1);
      expect_alu({6'h38, 5'd1, 5'd2, 5'd3, 11'h000}, 4'd0, 5'd0, 1'b0);
   endtask

   task automatic test_illegal;
      expect_except({6'h28, 5'd1, 5'd2, 16'h0001}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h31, 5'd1, 5'd2, 16'h0001}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h32, 5'd1, 5'd2, 16'h0000}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h1C, 26'h0000_123}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h3C, 26'h0000_456}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h1B, 5'd1, 5'd2, 16'h0000}, 1'b1, 1'b0, 1'b0);
      // ALU div, addc, ff1 and rotate
      expect_except({6'h38, 5'd1, 5'd2, 5'd3, 11'h009}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h38, 5'd1, 5'd2, 5'd3, 11'h001}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h38, 5'd1, 5'd2, 5'd3, 11'h00F}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h38, 5'd1, 5'd2, 5'd3, 11'h0C8}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h2E, 5'd1, 5'd2, 16'h00C5}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h08, 5'h01, 5'd0, 16'h0000}, 1'b1, 1'b0, 1'b0);
      expect_except({6'h08, 5'h00, 5'd0, 16'h0001}, 1'b0, 1'b1, 1'b0);
      expect_except({6'h08, 5'h08, 5'd0, 16'h0002}, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic test_stream;
      logic [31:0] w;
      logic [31:0] held_w;
      logic        v;
      logic        prev_v;
      logic        loaded;
      prev_v = 1'b0;
      loaded = 1'b0;
      held_w = '0;
      for (int i = 0; i <= 200; i++) begin
         @(negedge clk);
         if (valid_o !== prev_v)
            report_mismatch("valid_o in stream", held_w, valid_o, prev_v);
         // Registers hold the last accepted word while the input is idle
         if (loaded)
            check_outputs(held_w);
         w            = $random(seed);
         v            = (i < 200) && (($random(seed) & 3) != 0);
         insn_i       = w;
         insn_valid_i = v;
         prev_v       = v;
         if (v) begin
            held_w = w;
            loaded = 1'b1;
         end
      end
   endtask

   initial begin
      seed         = 32'h4ef367f3;
      errors       = 0;
      n_checked    = 0;
      rst_n_i      = 1'b0;
      insn_i       = '0;
      insn_valid_i = 1'b0;
      test_reset();
      test_classes();
      test_immediates();
      test_alu_ctrl();
      test_illegal();
      test_stream();
      $display("Decodes checked: %0d, errors: %0d", n_checked, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: sim.f
+incdir+design
+incdir+sim
design/or1k_decode_pkg.sv
design/decode_class.sv
design/decode_imm.sv
design/decode_alu_ctrl.sv
design/decode_illegal.sv
design/decode_stage.sv
sim/tb_decode_stage.sv
